/* compile.f */
logic/mont_ctrl_pkg.sv
logic/mont_data_pkg.sv
logic/digit_counter.sv
logic/mont_ctrl.sv
logic/multiple_table.sv
logic/mont_datapath.sv
logic/mont_mult_top.sv
dv/mont_mult_assert.sv
dv/tb_mont_mult.sv

/* Bender.yml */
package:
  name: mont_mult

sources:
  - files:
      - logic/mont_ctrl_pkg.sv
      - logic/mont_data_pkg.sv
      - logic/digit_counter.sv
      - logic/mont_ctrl.sv
      - logic/multiple_table.sv
      - logic/mont_datapath.sv
      - logic/mont_mult_top.sv

  - target: test
    files:
      - dv/mont_mult_assert.sv
      - dv/tb_mont_mult.sv

/* dv/tb_mont_mult.sv */
`timescale 1ns/1ns

module tb_mont_mult;

    localparam int WIDTH      = 16;
    localparam int FIXED_ROWS = 8;
    localparam int RAND_ROWS  = 8;
    localparam int NUM_ROWS   = FIXED_ROWS + RAND_ROWS;
    // whole cycles from accepted start to done
    localparam int DONE_LAT   = WIDTH + 3;
    localparam int MAX_CYCLES = NUM_ROWS * (WIDTH + 10) + 50;

    typedef struct packed {
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] expected;
    } row_t;

    logic             clk;
    logic             resetn;
    logic             start;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] m;
    logic [WIDTH-1:0] result;
    logic             done;
    logic             busy;

    row_t        rows [NUM_ROWS];
    string       labels [NUM_ROWS];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycle_count;

    mont_mult_top #(
        .WIDTH (WIDTH)
    ) u_mont_mult_top (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // radix-2 bit-serial montgomery with one final subtraction
    function automatic logic [WIDTH-1:0] mont_ref(input logic [WIDTH-1:0] ra,
                                                  input logic [WIDTH-1:0] rb,
                                                  input logic [WIDTH-1:0] rm);
        logic [2*WIDTH+1:0] t;
        logic [2*WIDTH+1:0] ta;
        logic [2*WIDTH+1:0] tb;
        logic [2*WIDTH+1:0] tm;
        int                 i;
        ta = ra;
        tb = rb;
        tm = rm;
        t  = ta * tb;
        for (i = 0; i < WIDTH; i++) begin
            if (t[0]) begin
                t = t + tm;
            end
            t = t >> 1;
        end
        if (t >= tm) begin
            t = t - tm;
        end
        return t[WIDTH-1:0];
    endfunction

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    function automatic logic [WIDTH-1:0] take_bits(input int n);
        logic [WIDTH-1:0] bits;
        int               i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits   = {bits[WIDTH-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return bits;
    endfunction

    task automatic set_row(input int idx, input logic [WIDTH-1:0] ra,
                           input logic [WIDTH-1:0] rb, input logic [WIDTH-1:0] rm,
                           input string label);
        rows[idx].a        = ra;
        rows[idx].b        = rb;
        rows[idx].m        = rm;
        rows[idx].expected = mont_ref(ra, rb, rm);
        labels[idx]        = label;
    endtask

    task automatic build_table();
        logic [WIDTH-1:0] rm;
        logic [WIDTH-1:0] ra;
        logic [WIDTH-1:0] rb;
        int               i;
        set_row(0, 16'h1234, 16'h0567, 16'hf00d, "m low 01");
        set_row(1, 16'h0abc, 16'h1def, 16'hc35b, "m low 11");
        set_row(2, 16'h0000, 16'h4321, 16'h8001, "a zero");
        set_row(3, 16'h2222, 16'h0000, 16'h9999, "b zero");
        set_row(4, 16'hfff0, 16'hfff0, 16'hfff1, "a=b=m-1 low 01");
        set_row(5, 16'he3a6, 16'he3a6, 16'he3a7, "a=b=m-1 low 11");
        set_row(6, 16'h0004, 16'h0003, 16'h0005, "small m");
        set_row(7, 16'hfffe, 16'h8000, 16'hffff, "m all ones");
        for (i = 0; i < RAND_ROWS; i++) begin
            // m forced odd and operands reduced below m
            rm = take_bits(WIDTH) | 1'b1;
            ra = take_bits(WIDTH) % rm;
            rb = take_bits(WIDTH) % rm;
            set_row(FIXED_ROWS + i, ra, rb, rm, $sformatf("lfsr %0d", i));
        end
    endtask

    task automatic run_row(input int idx, input bit intrude);
        int k;
        bit seen;
        k    = 0;
        seen = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        a     <= rows[idx].a;
        b     <= rows[idx].b;
        m     <= rows[idx].m;
        // this edge accepts the start
        @(posedge clk);
        start <= 1'b0;
        while (!seen && k < DONE_LAT + 4) begin
            @(negedge clk);
            k++;
            checks++;
            if (busy !== 1'b1) begin
                errors++;
                $display("FAIL t=%0t busy got=%b expected=1 (row %s, cycle %0d)",
                         $time, busy, labels[idx], k);
            end
            if (done === 1'b1) begin
                seen = 1'b1;
                checks++;
                if (k != DONE_LAT) begin
                    errors++;
                    $display("FAIL t=%0t done latency got=%0d expected=%0d (row %s)",
                             $time, k, DONE_LAT, labels[idx]);
                end
                checks++;
                if (result !== rows[idx].expected) begin
                    errors++;
                    $display("FAIL t=%0t result got=%h expected=%h (row %s)",
                             $time, result, rows[idx].expected, labels[idx]);
                end
            end else begin
                @(posedge clk);
                // second request mid-run must be dropped
                if (intrude && k == 2) begin
                    start <= 1'b1;
                    a     <= ~rows[idx].a;
                    b     <= ~rows[idx].b;
                    m     <= rows[idx].m + 2'd2;
                end else begin
                    start <= 1'b0;
                end
            end
        end
        if (!seen) begin
            errors++;
            $display("row %s: done never pulsed within %0d cycles of the accepted start",
                     labels[idx], DONE_LAT + 4);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run passed %0d cycles, checks run: %0d, errors: %0d",
                 MAX_CYCLES, checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int idx;
        int assert_fails;
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        errors = 0;
        checks = 0;
        lfsr_q = 32'hdfbc;
        build_table();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        // idle outputs right after reset
        checks++;
        if (done !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t done got=%b expected=0", $time, done);
        end
        checks++;
        if (busy !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t busy got=%b expected=0", $time, busy);
        end
        checks++;
        if (result !== '0) begin
            errors++;
            $display("FAIL t=%0t result got=%h expected=%h", $time, result, {WIDTH{1'b0}});
        end
        for (idx = 0; idx < NUM_ROWS; idx++) begin
            run_row(idx, (idx % 2) == 1);
        end
        // let the last done settle through the bound checks
        repeat (2) @(negedge clk);
        assert_fails = u_mont_mult_top.u_mont_mult_assert.fail_count;
        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/mont_mult_assert.sv */
`timescale 1ns/1ns

module mont_mult_assert #(
    parameter int WIDTH = 1024
) (
    input logic             clk,
    input logic             resetn,
    input logic             start,
    input logic             busy,
    input logic             done,
    input logic [WIDTH-1:0] m,
    input logic [WIDTH-1:0] result
);

    logic [WIDTH-1:0] m_cap;

    // assertion failures seen so far
    int fail_count = 0;

    // modulus of the running operation
    always_ff @(posedge clk) begin
        if (!resetn) begin
            m_cap <= '0;
        end else if (start && !busy) begin
            m_cap <= m;
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    done_within_busy: assert property (@(posedge clk) disable iff (!resetn)
        done |-> busy)
        else begin
            fail_count++;
            $error("done high while busy is low");
        end

    result_below_m: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (result < m_cap))
        else begin
            fail_count++;
            $error("result %h not below modulus %h at done", result, m_cap);
        end

endmodule

bind mont_mult_top mont_mult_assert #(
    .WIDTH (WIDTH)
) u_mont_mult_assert (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .m      (m),
    .result (result)
);

/* logic/mont_mult_top.sv */
`timescale 1ns/1ns

module mont_mult_top #(
    parameter int WIDTH = 1024
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] m,
    output logic [WIDTH-1:0] result,
    output logic             done,
    output logic             busy
);

    localparam int EXT_W = WIDTH + mont_data_pkg::GUARD_BITS;

    mont_ctrl_pkg::mont_cmd_t cmd;
    logic                     last;
    mont_data_pkg::mult_sel_e b_sel;
    mont_data_pkg::mult_sel_e m_sel;
    logic [EXT_W-1:0]         b_mult;
    logic [EXT_W-1:0]         m_mult;

    mont_ctrl u_mont_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .last   (last),
        .cmd    (cmd),
        .busy   (busy),
        .done   (done)
    );

    // one step per add_m, so one count per digit of a
    digit_counter #(
        .DIGITS (WIDTH / 2)
    ) u_digit_counter (
        .clk    (clk),
        .resetn (resetn),
        .clear  (cmd.load),
        .step   (cmd.add_m),
        .last   (last)
    );

    // b, 2b, 3b
    multiple_table #(
        .WIDTH (WIDTH)
    ) u_b_table (
        .clk      (clk),
        .resetn   (resetn),
        .load     (cmd.load),
        .operand  (b),
        .sel      (b_sel),
        .multiple (b_mult)
    );

    // m, 2m, 3m
    multiple_table #(
        .WIDTH (WIDTH)
    ) u_m_table (
        .clk      (clk),
        .resetn   (resetn),
        .load     (cmd.load),
        .operand  (m),
        .sel      (m_sel),
        .multiple (m_mult)
    );

    mont_datapath #(
        .WIDTH (WIDTH)
    ) u_mont_datapath (
        .clk    (clk),
        .resetn (resetn),
        .cmd    (cmd),
        .a      (a),
        .m      (m),
        .b_mult (b_mult),
        .m_mult (m_mult),
        .b_sel  (b_sel),
        .m_sel  (m_sel),
        .result (result)
    );

endmodule

/* logic/mont_datapath.sv */
`timescale 1ns/1ns

module mont_datapath #(
    parameter int WIDTH = 1024
) (
    input  logic                                       clk,
    input  logic                                       resetn,
    input  mont_ctrl_pkg::mont_cmd_t                   cmd,
    input  logic [WIDTH-1:0]                           a,
    input  logic [WIDTH-1:0]                           m,
    input  logic [WIDTH+mont_data_pkg::GUARD_BITS-1:0] b_mult,
    input  logic [WIDTH+mont_data_pkg::GUARD_BITS-1:0] m_mult,
    output mont_data_pkg::mult_sel_e                   b_sel,
    output mont_data_pkg::mult_sel_e                   m_sel,
    output logic [WIDTH-1:0]                           result
);

    localparam int EXT_W = WIDTH + mont_data_pkg::GUARD_BITS;
    localparam int DB    = mont_data_pkg::DIGIT_BITS;

    logic [WIDTH-1:0]  a_q;
    logic [DB-1:0]     m_lo_q;
    logic [EXT_W-1:0]  acc_q;
    logic [EXT_W-1:0]  sum_b;
    logic [EXT_W-1:0]  sum_m;
    logic [EXT_W-1:0]  diff;
    logic              acc_ge_m;
    mont_data_pkg::mult_sel_e q_sel;

    // quotient digit makes acc + q*m divisible by 4
    always_comb begin
        case (acc_q[DB-1:0])
            2'b00: begin
                q_sel = mont_data_pkg::none;
            end
            2'b10: begin
                q_sel = mont_data_pkg::x2;
            end
            default: begin
                // odd acc, m is odd too
                if (acc_q[DB-1:0] == m_lo_q) begin
                    q_sel = mont_data_pkg::x3;
                end else begin
                    q_sel = mont_data_pkg::x1;
                end
            end
        endcase
    end

    // table selects, idle at none outside their step
    always_comb begin
        b_sel = mont_data_pkg::none;
        m_sel = mont_data_pkg::none;
        if (cmd.add_b) begin
            b_sel = mont_data_pkg::mult_sel_e'(a_q[DB-1:0]);
        end
        if (cmd.add_m) begin
            m_sel = q_sel;
        end else if (cmd.reduce) begin
            // plain m for the final compare and subtract
            m_sel = mont_data_pkg::x1;
        end
    end

    assign sum_b    = acc_q + b_mult;
    assign sum_m    = acc_q + m_mult;
    assign diff     = acc_q - m_mult;
    assign acc_ge_m = (acc_q >= m_mult);

    // a digits, low digit first
    always_ff @(posedge clk) begin
        if (cmd.load) begin
            a_q    <= a;
            m_lo_q <= m[DB-1:0];
        end else if (cmd.add_m) begin
            a_q <= a_q >> DB;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.load) begin
            acc_q <= '0;
        end else if (cmd.add_b) begin
            acc_q <= sum_b;
        end else if (cmd.add_m) begin
            // low two bits are zero here, the shift is exact
            acc_q <= sum_m >> DB;
        end
    end

    // acc is below 2m at reduce, one subtraction is enough
    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else if (cmd.reduce) begin
            if (acc_ge_m) begin
                result <= diff[WIDTH-1:0];
            end else begin
                result <= acc_q[WIDTH-1:0];
            end
        end
    end

endmodule

/* logic/multiple_table.sv */
`timescale 1ns/1ns

module multiple_table #(
    parameter int WIDTH = 1024
) (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          load,
    input  logic [WIDTH-1:0]                              operand,
    input  mont_data_pkg::mult_sel_e                      sel,
    output logic [WIDTH+mont_data_pkg::GUARD_BITS-1:0]    multiple
);

    localparam int EXT_W = WIDTH + mont_data_pkg::GUARD_BITS;

    logic [EXT_W-1:0] op_ext;
    logic [EXT_W-1:0] op_dbl;
    logic [EXT_W-1:0] op_tpl;
    logic [EXT_W-1:0] x1_q;
    logic [EXT_W-1:0] x2_q;
    logic [EXT_W-1:0] x3_q;
    logic             loaded_q;

    assign op_ext = {{mont_data_pkg::GUARD_BITS{1'b0}}, operand};
    // double is free, triple needs the one adder
    assign op_dbl = op_ext << 1;
    assign op_tpl = op_ext + op_dbl;

    always_ff @(posedge clk) begin
        if (load) begin
            x1_q <= op_ext;
            x2_q <= op_dbl;
            x3_q <= op_tpl;
        end
    end

    // table contents undefined until the first load
    always_ff @(posedge clk) begin
        if (!resetn) begin
            loaded_q <= 1'b0;
        end else if (load) begin
            loaded_q <= 1'b1;
        end
    end

    always_comb begin
        multiple = '0;
        if (loaded_q) begin
            case (sel)
                mont_data_pkg::x1: multiple = x1_q;
                mont_data_pkg::x2: multiple = x2_q;
                mont_data_pkg::x3: multiple = x3_q;
                default:           multiple = '0;
            endcase
        end
    end

endmodule

/* logic/mont_ctrl.sv */
`timescale 1ns/1ns

module mont_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic                   last,
    output mont_ctrl_pkg::mont_cmd_t cmd,
    output logic                   busy,
    output logic                   done
);

    mont_ctrl_pkg::mont_state_e state_q;
    mont_ctrl_pkg::mont_state_e state_d;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= mont_ctrl_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            mont_ctrl_pkg::idle: begin
                // start while busy never reaches here, so it is dropped
                if (start) begin
                    state_d = mont_ctrl_pkg::load;
                end
            end
            mont_ctrl_pkg::load: begin
                state_d = mont_ctrl_pkg::add_b;
            end
            mont_ctrl_pkg::add_b: begin
                state_d = mont_ctrl_pkg::add_m;
            end
            mont_ctrl_pkg::add_m: begin
                // counter flags the final digit during its add_m
                if (last) begin
                    state_d = mont_ctrl_pkg::reduce;
                end else begin
                    state_d = mont_ctrl_pkg::add_b;
                end
            end
            mont_ctrl_pkg::reduce: begin
                state_d = mont_ctrl_pkg::finish;
            end
            mont_ctrl_pkg::finish: begin
                state_d = mont_ctrl_pkg::idle;
            end
            default: begin
                state_d = mont_ctrl_pkg::idle;
            end
        endcase
    end

    // step strobes
    always_comb begin
        cmd = '0;
        // operands are only guaranteed while start is high,
        // so the load strobe rides on the accepting cycle and
        // the load state is the cycle where the tables settle
        cmd.load = (state_q == mont_ctrl_pkg::idle) && start;
        case (state_q)
            mont_ctrl_pkg::add_b: begin
                cmd.add_b = 1'b1;
            end
            mont_ctrl_pkg::add_m: begin
                cmd.add_m = 1'b1;
            end
            mont_ctrl_pkg::reduce: begin
                cmd.reduce = 1'b1;
            end
            mont_ctrl_pkg::finish: begin
                cmd.finish = 1'b1;
            end
            default: begin
                cmd.add_b = 1'b0;
            end
        endcase
    end

    // busy covers load through finish, done is the finish cycle
    assign busy = (state_q != mont_ctrl_pkg::idle);
    assign done = cmd.finish;

endmodule

/* logic/digit_counter.sv */
`timescale 1ns/1ns

module digit_counter #(
    parameter int DIGITS = 512
) (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  logic step,
    output logic last
);

    localparam int CNT_W = (DIGITS > 1) ? $clog2(DIGITS) : 1;

    logic [CNT_W-1:0] count_q;

    // digits fully processed in the current operation
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (step) begin
            // wrap on the final digit, ready for the next run
            if (last) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign last = (count_q == CNT_W'(DIGITS - 1));

endmodule

/* logic/mont_data_pkg.sv */
package mont_data_pkg;

    // radix-4, so each digit of a is two bits
    localparam int DIGIT_BITS = 2;

    // headroom above WIDTH for the accumulator and the stored multiples
    // acc stays below 2m, so acc + 3b + 3m is below 8m
    localparam int GUARD_BITS = 3;

    // which stored multiple a table puts on its output
    // encoding matches a raw two-bit digit, so a digit casts straight in
    typedef enum logic [1:0] {
        none = 2'd0,
        x1   = 2'd1,
        x2   = 2'd2,
        x3   = 2'd3
    } mult_sel_e;

endpackage

/* logic/mont_ctrl_pkg.sv */
package mont_ctrl_pkg;

    // operation phases of the multiplier
    // load is the settle cycle after operands are captured
    typedef enum logic [2:0] {
        idle   = 3'd0,
        load   = 3'd1,
        add_b  = 3'd2,
        add_m  = 3'd3,
        reduce = 3'd4,
        finish = 3'd5
    } mont_state_e;

    // one strobe per step, at most one high in any cycle
    typedef struct packed {
        // capture operands, build multiples, clear accumulator
        logic load;
        // accumulate a-digit multiple of b
        logic add_b;
        // accumulate quotient multiple of m, then divide by 4
        logic add_m;
        // conditional subtract and latch result
        logic reduce;
        // result handed to the outside
        logic finish;
    } mont_cmd_t;

endpackage
